/* bench/tb_clock.sv */
/*
 * clock and reset generator for the fetch stage testbench
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int ClkPeriod = 100,
  parameter int RstCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_o = ~clk_o;
    end
  end

  // held low over the first rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/tb_if_stage.sv */
/*
 * testbench for the instruction fetch stage
 * bus memory model with random delays, redirects, stalls and an ID checker
 */

`timescale 1ns/1ps
`default_nettype none

module tb_if_stage import if_addr_pkg::*, if_ctrl_pkg::*; ();

  localparam addr_t BootAddr    = 32'h0000_1080;
  localparam addr_t DmHaltAddr  = 32'h0000_0800;
  localparam addr_t DmExcAddr   = 32'h0000_0900;
  // the one word that answers with a bus error
  localparam addr_t ErrAddr     = 32'h0000_7008;
  localparam int    WordTimeout = 60;

  logic        clk_i;
  logic        rst_ni;
  addr_t       boot_addr_i;
  logic        req_i;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  instr_t      instr_rdata_i;
  logic        instr_err_i;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  instr_t      instr_rdata_id_o;
  logic        instr_fetch_err_o;
  addr_t       pc_if_o;
  addr_t       pc_id_o;
  logic        instr_valid_clear_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  addr_t       branch_target_ex_i;
  addr_t       csr_mepc_i;
  addr_t       csr_depc_i;
  addr_t       csr_mtvec_i;
  logic        csr_mtvec_init_o;
  logic        id_in_ready_i;
  logic        pc_mismatch_alert_o;
  logic        if_busy_o;

  // checker state, written by the stimulus on each redirect
  addr_t  exp_pc;
  int     new_count;
  int     errors;
  int     tests;
  int     test_first_err;
  logic   err_seen;
  integer seed = 32'h5244;
  integer bus_seed;
  integer stall_seed;

  tb_clock clock_gen_i (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  if_stage #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExcAddr)
  ) if_stage_i (.*);

  // reference memory contents, odd multiplier spreads every address bit
  function automatic instr_t mem_word(input addr_t addr);
    return (addr * 32'h9E37_79B1) ^ 32'h0000_0013;
  endfunction

  // stimulus changes 10 ns after the rising edge
  task automatic next_slot();
    @(posedge clk_i);
    #10;
  endtask

  task automatic begin_test();
    test_first_err = errors;
    tests++;
  endtask

  task automatic end_test(input string name);
    if (errors == test_first_err) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_first_err);
    end
  endtask

  task automatic check_low(input logic value, input string name);
    if (value !== 1'b0) begin
      $display("FAILED %s: got %h expected 0", name, value);
      errors++;
    end
  endtask

  task automatic wait_words(input int n, input string what);
    int target;
    int cycles;
    target = new_count + n;
    cycles = 0;
    while (new_count < target && cycles < WordTimeout * n) begin
      next_slot();
      cycles++;
    end
    if (new_count < target) begin
      $display("timeout: %s got only %0d of %0d words", what, n - (target - new_count), n);
      errors++;
    end
  endtask

  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e exc_sel, input addr_t target);
    pc_mux_i     = sel;
    exc_pc_mux_i = exc_sel;
    pc_set_i     = 1'b1;
    exp_pc       = target;
    #1;
    // mtvec init only with a boot redirect
    if (csr_mtvec_init_o !== (sel == PC_BOOT)) begin
      $display("FAILED csr_mtvec_init_o: got %h expected %h", csr_mtvec_init_o, sel == PC_BOOT);
      errors++;
    end
    next_slot();
    pc_set_i = 1'b0;
  endtask

  task automatic jump_test(input pc_sel_e sel, input exc_pc_sel_e exc_sel, input addr_t target,
                           input string name);
    begin_test();
    wait_words(2, name);
    redirect(sel, exc_sel, target);
    wait_words(3, name);
    end_test(name);
  endtask

  // bus slave, one request at a time, random grant and response delays
  initial begin : bus_model
    logic [31:0] r;
    logic [1:0]  gnt_cnt;
    logic [1:0]  resp_cnt;
    logic        resp_pending;
    addr_t       resp_addr;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    gnt_cnt        = 2'd0;
    resp_cnt       = 2'd0;
    resp_pending   = 1'b0;
    resp_addr      = '0;
    forever begin
      next_slot();
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (resp_pending) begin
        if (resp_cnt == 2'd0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = mem_word(resp_addr);
          instr_err_i    = (resp_addr == ErrAddr);
          resp_pending   = 1'b0;
        end else begin
          resp_cnt--;
        end
      end else if (instr_req_o === 1'b1) begin
        if (gnt_cnt == 2'd0) begin
          instr_gnt_i  = 1'b1;
          resp_addr    = instr_addr_o;
          resp_pending = 1'b1;
          // response 1 to 3 cycles after the grant
          r            = $random(bus_seed);
          resp_cnt     = (r[1:0] == 2'd3) ? 2'd0 : r[1:0];
          r            = $random(bus_seed);
          gnt_cnt      = r[1:0];
        end else begin
          gnt_cnt--;
        end
      end
    end
  end

  // compares every new ID word, sampled mid cycle
  initial begin : id_checker
    instr_t exp_data;
    forever begin
      @(posedge clk_i);
      #5;
      if (rst_ni === 1'b1) begin
        if (pc_mismatch_alert_o !== 1'b0) begin
          $display("FAILED pc_mismatch_alert_o: got %h expected 0, pc_if_o %h pc_id_o %h",
                   pc_mismatch_alert_o, pc_if_o, pc_id_o);
          errors++;
        end
        // a pending bus request keeps the stage busy
        if (instr_req_o === 1'b1 && if_busy_o !== 1'b1) begin
          $display("FAILED if_busy_o: got %h expected 1 with instr_req_o high", if_busy_o);
          errors++;
        end
        if (instr_new_id_o === 1'b1) begin
          exp_data = mem_word(exp_pc);
          if (pc_id_o !== exp_pc) begin
            $display("FAILED pc_id_o: got %h expected %h", pc_id_o, exp_pc);
            errors++;
          end
          // IF already points at the following word
          if (pc_if_o !== exp_pc + 32'd4) begin
            $display("FAILED pc_if_o: got %h expected %h", pc_if_o, exp_pc + 32'd4);
            errors++;
          end
          if (instr_rdata_id_o !== exp_data) begin
            $display("FAILED instr_rdata_id_o: got %h expected %h", instr_rdata_id_o, exp_data);
            errors++;
          end
          if (instr_fetch_err_o !== (exp_pc == ErrAddr)) begin
            $display("FAILED instr_fetch_err_o: got %h expected %h at pc %h",
                     instr_fetch_err_o, exp_pc == ErrAddr, exp_pc);
            errors++;
          end
          if (instr_valid_id_o !== 1'b1) begin
            $display("FAILED instr_valid_id_o: got %h expected 1", instr_valid_id_o);
            errors++;
          end
          if (exp_pc == ErrAddr && instr_fetch_err_o === 1'b1) begin
            err_seen = 1'b1;
          end
          exp_pc = exp_pc + 32'd4;
          new_count++;
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    int          cycles;
    int          target;
    addr_t       hold_pc;
    instr_t      hold_data;
    logic        hold_valid;
    boot_addr_i         = BootAddr;
    req_i               = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    branch_target_ex_i  = '0;
    csr_mepc_i          = 32'h0000_4404;
    csr_depc_i          = 32'h0000_5008;
    csr_mtvec_i         = 32'h0000_6181;
    id_in_ready_i       = 1'b1;
    bus_seed            = seed;
    stall_seed          = seed ^ 32'h0000_00ff;
    exp_pc              = '0;
    new_count           = 0;
    errors              = 0;
    tests               = 0;
    err_seen            = 1'b0;

    // boot, outputs quiet in reset, then the first bus address
    begin_test();
    @(posedge clk_i);
    #5;
    check_low(instr_req_o, "instr_req_o");
    check_low(instr_valid_id_o, "instr_valid_id_o");
    check_low(instr_new_id_o, "instr_new_id_o");
    check_low(if_busy_o, "if_busy_o");
    check_low(csr_mtvec_init_o, "csr_mtvec_init_o");
    check_low(pc_mismatch_alert_o, "pc_mismatch_alert_o");
    cycles = 0;
    while (rst_ni !== 1'b1 && cycles < 10) begin
      next_slot();
      cycles++;
    end
    if (rst_ni !== 1'b1) begin
      $display("timeout: reset was never released");
      errors++;
    end
    req_i = 1'b1;
    redirect(PC_BOOT, EXC_PC_EXC, BootAddr & 32'hFFFF_FF00);
    cycles = 0;
    while (instr_req_o !== 1'b1 && cycles < 20) begin
      next_slot();
      cycles++;
    end
    if (instr_req_o !== 1'b1) begin
      $display("timeout: no bus request after boot");
      errors++;
    end else if (instr_addr_o !== (BootAddr & 32'hFFFF_FF00)) begin
      $display("FAILED instr_addr_o: got %h expected %h", instr_addr_o,
               BootAddr & 32'hFFFF_FF00);
      errors++;
    end
    wait_words(1, "boot");
    end_test("boot");

    // sequential words with ID stalling at random
    begin_test();
    target = new_count + 24;
    cycles = 0;
    while (new_count < target && cycles < WordTimeout * 24) begin
      r             = $random(stall_seed);
      id_in_ready_i = (r[1:0] != 2'b00);
      next_slot();
      cycles++;
    end
    id_in_ready_i = 1'b1;
    if (new_count < target) begin
      $display("timeout: sequential fetch stopped after %0d words", 24 - (target - new_count));
      errors++;
    end
    end_test("sequential");

    // redirects, stale words in flight must never reach ID
    branch_target_ex_i = 32'h0000_3A40;
    jump_test(PC_JUMP, EXC_PC_EXC, 32'h0000_3A40, "jump");
    jump_test(PC_ERET, EXC_PC_EXC, 32'h0000_4404, "eret");
    jump_test(PC_DRET, EXC_PC_EXC, 32'h0000_5008, "dret");
    jump_test(PC_EXC, EXC_PC_EXC, 32'h0000_6100, "exception");
    jump_test(PC_EXC, EXC_PC_DBD, DmHaltAddr, "debug halt");

    // ID stall, outputs frozen and no new pulse
    begin_test();
    id_in_ready_i = 1'b0;
    next_slot();
    hold_pc    = pc_id_o;
    hold_data  = instr_rdata_id_o;
    hold_valid = instr_valid_id_o;
    repeat (6) begin
      next_slot();
      if (instr_new_id_o !== 1'b0) begin
        $display("FAILED instr_new_id_o: got %h expected 0", instr_new_id_o);
        errors++;
      end
      if (pc_id_o !== hold_pc || instr_rdata_id_o !== hold_data) begin
        $display("FAILED pc_id_o/instr_rdata_id_o: got %h/%h expected %h/%h",
                 pc_id_o, instr_rdata_id_o, hold_pc, hold_data);
        errors++;
      end
      if (instr_valid_id_o !== hold_valid) begin
        $display("FAILED instr_valid_id_o: got %h expected %h", instr_valid_id_o, hold_valid);
        errors++;
      end
    end
    id_in_ready_i = 1'b1;
    wait_words(3, "stall");
    end_test("stall");

    // valid clear holds until the next transfer
    begin_test();
    id_in_ready_i = 1'b0;
    next_slot();
    instr_valid_clear_i = 1'b1;
    next_slot();
    instr_valid_clear_i = 1'b0;
    repeat (3) begin
      if (instr_valid_id_o !== 1'b0) begin
        $display("FAILED instr_valid_id_o: got %h expected 0", instr_valid_id_o);
        errors++;
      end
      next_slot();
    end
    id_in_ready_i = 1'b1;
    wait_words(1, "valid clear");
    if (instr_valid_id_o !== 1'b1) begin
      $display("FAILED instr_valid_id_o: got %h expected 1", instr_valid_id_o);
      errors++;
    end
    end_test("valid clear");

    // bus error on one word, neighbours clean
    begin_test();
    err_seen           = 1'b0;
    branch_target_ex_i = 32'h0000_7000;
    redirect(PC_JUMP, EXC_PC_EXC, 32'h0000_7000);
    wait_words(5, "bus error");
    if (!err_seen) begin
      $display("the word with the bus error never reached ID with its error flag");
      errors++;
    end
    end_test("bus error");

    $display("tests %0d, words checked %0d, errors %0d", tests, new_count, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
common/if_addr_pkg.sv
common/if_ctrl_pkg.sv
common/fetch_if.sv
fetch/fetch_unit.sv
src/pc_select.sv
src/if_control.sv
src/if_id_regs.sv
src/pc_check.sv
src/if_stage.sv
bench/tb_clock.sv
bench/tb_if_stage.sv

/* common/fetch_if.sv */
/*
 * fetched word channel between the fetch unit and the IF-ID logic
 * valid/ready handshake with word, address and bus error
 */

`timescale 1ns/1ps
`default_nettype none

interface fetch_if import if_addr_pkg::*; ();

  logic   valid;
  logic   ready;
  instr_t rdata;
  addr_t  addr;
  logic   err;

  // producer side, the fetch unit
  modport fetch (output valid, rdata, addr, err, input ready);

  // handshake side, accepts words into IF-ID
  modport ctrl (input valid, output ready);

  // observers of the current word
  modport data (input valid, ready, rdata, addr, err);

endinterface

`default_nettype wire

/* common/if_addr_pkg.sv */
/*
 * address and instruction types of the fetch stage
 * widths, PC step and default debug module addresses
 */

`default_nettype none

package if_addr_pkg;

  parameter int unsigned ADDR_W  = 32;
  parameter int unsigned INSTR_W = 32;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INSTR_W-1:0] instr_t;

  // boot address and trap base are 256 byte aligned
  parameter int unsigned VEC_ALIGN_BITS = 8;

  // no compressed instructions, so the PC always steps by one word
  parameter addr_t INSTR_BYTES = addr_t'(4);

  // debug module entry points, overridable at the top level
  parameter addr_t DM_HALT_ADDR_DFLT = 32'h1A11_0800;
  parameter addr_t DM_EXC_ADDR_DFLT  = 32'h1A11_0808;

endpackage

`default_nettype wire

/* common/if_ctrl_pkg.sv */
/*
 * control encodings for the instruction fetch stage
 * next-PC source and exception vector source
 */

`default_nettype none

package if_ctrl_pkg;

  // next-PC source, driven by the controller with pc_set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception vector source, only used with PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

`default_nettype wire

/* fetch/fetch_unit.sv */
/*
 * instruction bus master with one outstanding request
 * fetches sequential words into a one-word buffer, flushed on redirect
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_unit import if_addr_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   req_i,
  input  logic   pc_set_i,
  input  addr_t  fetch_addr_i,
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  input  logic   instr_err_i,
  output logic   busy_o,
  fetch_if.fetch fetch_o
);

  logic   req_q, req_d;
  logic   outstanding_q, outstanding_d;
  logic   discard_q, discard_d;
  logic   buf_valid_q, buf_valid_d;
  addr_t  req_addr_q;
  addr_t  next_addr_q;
  addr_t  target_addr;
  addr_t  start_addr;
  instr_t buf_data_q;
  addr_t  buf_addr_q;
  logic   buf_err_q;
  logic   transfer;
  logic   rvalid_keep;
  logic   req_start;

  // redirect target, forced to a word boundary
  assign target_addr = {fetch_addr_i[ADDR_W-1:2], 2'b00};
  assign start_addr  = pc_set_i ? target_addr : next_addr_q;

  assign transfer    = buf_valid_q & fetch_o.ready;
  // a response that lines up with a redirect is stale too
  assign rvalid_keep = instr_rvalid_i & ~discard_q & ~pc_set_i;

  // new request only with the bus idle and room for the response
  assign req_start = req_i & ~req_q & ~outstanding_q & (pc_set_i | ~buf_valid_q | transfer);

  assign req_d         = req_start | (req_q & ~instr_gnt_i);
  assign outstanding_d = (req_q & instr_gnt_i) | (outstanding_q & ~instr_rvalid_i);
  // pending or granted request from before the redirect gets dropped
  assign discard_d     = (discard_q & ~instr_rvalid_i) |
                         (pc_set_i & (req_q | (outstanding_q & ~instr_rvalid_i)));

  always_comb begin
    buf_valid_d = buf_valid_q;
    if (pc_set_i) begin
      buf_valid_d = 1'b0;
    end else if (rvalid_keep) begin
      buf_valid_d = 1'b1;
    end else if (transfer) begin
      buf_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q         <= 1'b0;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
      buf_valid_q   <= 1'b0;
    end else begin
      req_q         <= req_d;
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
      buf_valid_q   <= buf_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_start) begin
      req_addr_q  <= start_addr;
      next_addr_q <= start_addr + INSTR_BYTES;
    end else if (pc_set_i) begin
      next_addr_q <= target_addr;
    end
    // buffer address tracks the next word due at IF, even when empty
    if (rvalid_keep) begin
      buf_data_q <= instr_rdata_i;
      buf_err_q  <= instr_err_i;
      buf_addr_q <= req_addr_q;
    end else if (pc_set_i) begin
      buf_addr_q <= target_addr;
    end else if (transfer) begin
      buf_addr_q <= buf_addr_q + INSTR_BYTES;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;
  assign busy_o       = req_q | outstanding_q;

  assign fetch_o.valid = buf_valid_q;
  assign fetch_o.rdata = buf_data_q;
  assign fetch_o.addr  = buf_addr_q;
  assign fetch_o.err   = buf_err_q;

  // the bus answers only granted requests
  a_rvalid_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> outstanding_q);

  // the bus grants only a pending request
  a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_gnt_i |-> instr_req_o);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the fetch stage testbench with Verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_if_stage -f build.f -Mdir obj_dir -o tb_if_stage \
  > sim.log 2>&1 \
  && ./obj_dir/tb_if_stage >> sim.log 2>&1 \
  || echo "sim failed" >> sim.log
cat sim.log
if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

/* src/if_control.sv */
/*
 * IF-ID handshake control
 * accepts fetched words, holds ID valid and new flags, reports busy
 */

`timescale 1ns/1ps
`default_nettype none

module if_control (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  id_in_ready_i,
  input  logic  pc_set_i,
  input  logic  instr_valid_clear_i,
  input  logic  fetch_busy_i,
  output logic  instr_valid_id_o,
  output logic  instr_new_id_o,
  output logic  if_busy_o,
  output logic  pipe_we_o,
  fetch_if.ctrl fetch_i
);

  logic instr_valid_id_q, instr_valid_id_d;
  logic instr_new_id_q;

  // ID takes a word whenever it can
  assign fetch_i.ready = id_in_ready_i;

  // a word accepted during a redirect is squashed
  assign pipe_we_o = fetch_i.valid & id_in_ready_i & ~pc_set_i;

  // valid holds until the controller clears it
  assign instr_valid_id_d = pipe_we_o | (instr_valid_id_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_q <= 1'b0;
      instr_new_id_q   <= 1'b0;
    end else begin
      instr_valid_id_q <= instr_valid_id_d;
      // one cycle pulse per accepted word
      instr_new_id_q   <= pipe_we_o;
    end
  end

  assign instr_valid_id_o = instr_valid_id_q;
  assign instr_new_id_o   = instr_new_id_q;

  // busy while the bus side has a request in progress
  assign if_busy_o = fetch_busy_i;

  // a fetched word stays offered until ID takes it or a redirect drops it
  a_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_i.valid && !id_in_ready_i && !pc_set_i |=> fetch_i.valid);

endmodule

`default_nettype wire

/* src/if_id_regs.sv */
/*
 * IF-ID pipeline register
 * instruction word, PC and fetch error, frozen while ID stalls
 */

`timescale 1ns/1ps
`default_nettype none

module if_id_regs import if_addr_pkg::*; (
  input  logic   clk_i,
  input  logic   pipe_we_i,
  output instr_t instr_rdata_id_o,
  output addr_t  pc_id_o,
  output logic   instr_fetch_err_o,
  output addr_t  pc_if_o,
  fetch_if.data  fetch_i
);

  // payload only, qualified by the valid flag in if_control
  always_ff @(posedge clk_i) begin
    if (pipe_we_i) begin
      instr_rdata_id_o  <= fetch_i.rdata;
      pc_id_o           <= fetch_i.addr;
      instr_fetch_err_o <= fetch_i.err;
    end
  end

  // address of the word currently at IF
  assign pc_if_o = fetch_i.addr;

endmodule

`default_nettype wire

/* src/if_stage.sv */
/*
 * instruction fetch stage top level
 * PC selection, bus fetch, IF-ID register and PC increment check
 */

`timescale 1ns/1ps
`default_nettype none

module if_stage import if_addr_pkg::*, if_ctrl_pkg::*; #(
  parameter addr_t DmHaltAddr      = DM_HALT_ADDR_DFLT,
  parameter addr_t DmExceptionAddr = DM_EXC_ADDR_DFLT
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  addr_t       boot_addr_i,
  input  logic        req_i,
  // instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_err_i,
  // towards ID
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output instr_t      instr_rdata_id_o,
  output logic        instr_fetch_err_o,
  output addr_t       pc_if_o,
  output addr_t       pc_id_o,
  // control from the controller
  input  logic        instr_valid_clear_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  addr_t       branch_target_ex_i,
  // CSRs
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output logic        csr_mtvec_init_o,
  input  logic        id_in_ready_i,
  output logic        pc_mismatch_alert_o,
  output logic        if_busy_o
);

  addr_t fetch_addr_n;
  logic  fetch_busy;
  logic  pipe_we;

  fetch_if fetch_bus ();

  pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) pc_select_i (
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .pc_set_i           (pc_set_i),
    .fetch_addr_o       (fetch_addr_n),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  fetch_unit fetch_unit_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fetch_addr_i   (fetch_addr_n),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (fetch_busy),
    .fetch_o        (fetch_bus.fetch)
  );

  if_control if_control_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_busy_i        (fetch_busy),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .if_busy_o           (if_busy_o),
    .pipe_we_o           (pipe_we),
    .fetch_i             (fetch_bus.ctrl)
  );

  if_id_regs if_id_regs_i (
    .clk_i             (clk_i),
    .pipe_we_i         (pipe_we),
    .instr_rdata_id_o  (instr_rdata_id_o),
    .pc_id_o           (pc_id_o),
    .instr_fetch_err_o (instr_fetch_err_o),
    .pc_if_o           (pc_if_o),
    .fetch_i           (fetch_bus.data)
  );

  pc_check pc_check_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pipe_we_i           (pipe_we),
    .pc_set_i            (pc_set_i),
    .pc_id_i             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o),
    .fetch_i             (fetch_bus.data)
  );

endmodule

`default_nettype wire

/* src/pc_check.sv */
/*
 * sequential PC check
 * alerts when the IF address is not the ID address plus one word
 */

`timescale 1ns/1ps
`default_nettype none

module pc_check import if_addr_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  pipe_we_i,
  input  logic  pc_set_i,
  input  addr_t pc_id_i,
  output logic  pc_mismatch_alert_o,
  fetch_if.data fetch_i
);

  logic  prev_seq_q, prev_seq_d;
  addr_t pc_id_incr;

  // armed by a transfer, disarmed by any redirect
  assign prev_seq_d = (prev_seq_q | pipe_we_i) & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_seq_q <= 1'b0;
    end else begin
      prev_seq_q <= prev_seq_d;
    end
  end

  assign pc_id_incr = pc_id_i + INSTR_BYTES;

  // IF must follow straight on from ID
  assign pc_mismatch_alert_o = prev_seq_q & (fetch_i.addr != pc_id_incr);

endmodule

`default_nettype wire

/* src/pc_select.sv */
/*
 * next fetch address selection
 * exception vector mux, next-PC mux and mtvec init on boot
 */

`timescale 1ns/1ps
`default_nettype none

module pc_select import if_addr_pkg::*, if_ctrl_pkg::*; #(
  parameter addr_t DmHaltAddr      = DM_HALT_ADDR_DFLT,
  parameter addr_t DmExceptionAddr = DM_EXC_ADDR_DFLT
) (
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_ex_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  logic        pc_set_i,
  output addr_t       fetch_addr_o,
  output logic        csr_mtvec_init_o
);

  // clears the low bits of a vector base
  localparam addr_t VecBaseMask = ~addr_t'((1 << VEC_ALIGN_BITS) - 1);

  addr_t exc_pc;
  addr_t boot_pc;

  assign boot_pc = boot_addr_i & VecBaseMask;

  // traps and interrupts share the mtvec base, no vectored mode
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = csr_mtvec_i & VecBaseMask;
      EXC_PC_IRQ:     exc_pc = csr_mtvec_i & VecBaseMask;
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = csr_mtvec_i & VecBaseMask;
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_o = boot_pc;
      PC_JUMP: fetch_addr_o = branch_target_ex_i;
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap or from debug mode
      PC_ERET: fetch_addr_o = csr_mepc_i;
      PC_DRET: fetch_addr_o = csr_depc_i;
      default: fetch_addr_o = boot_pc;
    endcase
  end

  // CSR file loads mtvec from the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  // controller must give a legal source with every redirect
  always_comb begin
    if (pc_set_i) begin
      a_pc_mux_known: assert (pc_mux_i inside {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET, PC_DRET});
    end
  end

endmodule

`default_nettype wire
